/* hdl/rv_serial_pkg.sv */
package rv_serial_pkg;

   // Operand width and bit counter width
   localparam int XLEN  = 32;
   localparam int CNT_W = 5;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      LOAD   = 5'b00000,
      OP_IMM = 5'b00100,
      AUIPC  = 5'b00101,
      STORE  = 5'b01000,
      OP     = 5'b01100,
      LUI    = 5'b01101,
      BRANCH = 5'b11000,
      JALR   = 5'b11001,
      JAL    = 5'b11011,
      SYSTEM = 5'b11100
   } opcode_e;

   // Serial ALU operation
   typedef enum logic [2:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      CMP
   } alu_op_e;

   // Branch compare, negated by funct3 bit 0
   typedef enum logic [1:0] {
      EQ,
      LT,
      LTU
   } cmp_e;

endpackage

/* hdl/rv_csr_pkg.sv */
package rv_csr_pkg;

   // Short CSR address for the four machine CSRs kept in the core
   typedef enum logic [1:0] {
      MSCRATCH = 2'b00,
      MTVEC    = 2'b01,
      MEPC     = 2'b10,
      MTVAL    = 2'b11
   } csr_addr_e;

   // CSR write source, straight from funct3[1:0]
   typedef enum logic [1:0] {
      CSR = 2'b00,
      EXT = 2'b01,
      SET = 2'b10,
      CLR = 2'b11
   } csr_src_e;

endpackage

/* hdl/alu_ctrl_if.sv */
`timescale 1ns/1ps

interface alu_ctrl_if;

   rv_serial_pkg::alu_op_e alu_op;
   rv_serial_pkg::cmp_e    cmp_sel;
   logic                   cmp_neg;
   // Operand b from the immediate stream instead of rs2
   logic                   op_b_imm;
   logic                   imm_bit;
   // Operand a forced to zero, used by LUI
   logic                   zero_a;
   logic                   is_branch;
   logic                   rd_alu_en;

   modport ctrl (
      output alu_op, cmp_sel, cmp_neg, op_b_imm, imm_bit, zero_a, is_branch, rd_alu_en
   );

   modport alu (
      input alu_op, cmp_sel, cmp_neg, op_b_imm, imm_bit, zero_a, is_branch, rd_alu_en
   );

endinterface

/* hdl/bit_counter.sv */
`timescale 1ns/1ps

module bit_counter (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_start,
   output logic o_bit_en,
   output logic o_last,
   output logic o_done
);

   logic                             busy;
   logic [rv_serial_pkg::CNT_W-1:0] cnt;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         busy   <= 1'b0;
         cnt    <= '0;
         o_done <= 1'b0;
      end else begin
         o_done <= o_last;
         if (busy) begin
            // Count wraps to zero after the last bit
            cnt <= cnt + 1'b1;
            if (o_last) begin
               busy <= 1'b0;
            end
         end else if (i_start) begin
            // Start pulses while busy are dropped here
            busy <= 1'b1;
            cnt  <= '0;
         end
      end
   end

   assign o_bit_en = busy;
   assign o_last   = busy && (cnt == '1);

endmodule

/* hdl/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
   input  logic                            clk,
   input  logic                            i_rst_n,
   input  logic                            i_load,
   input  logic [rv_serial_pkg::XLEN-1:0] i_instr,
   input  logic                            i_bit_en,
   output logic [4:0]                      o_rd_addr,
   output logic [4:0]                      o_rs1_addr,
   output logic [4:0]                      o_rs2_addr,
   output logic                            o_rd_en,
   output logic                            o_ecall,
   output logic                            o_ebreak,
   output logic                            o_mret,
   output logic                            o_csr_en,
   output rv_csr_pkg::csr_addr_e           o_csr_addr,
   output rv_csr_pkg::csr_src_e            o_csr_src,
   alu_ctrl_if.ctrl                        ctrl
);

   rv_serial_pkg::opcode_e opcode;
   rv_serial_pkg::opcode_e in_opcode;
   logic [2:0]             funct3;
   logic                   bit30;
   logic                   op20;
   logic                   op21;
   logic                   op22;
   logic                   op26;

   // Immediate bits 11:0 and 30:12, sign kept apart
   logic                   signbit;
   logic [11:0]            imm_lo;
   logic [18:0]            imm_hi;
   logic [11:0]            in_imm_lo;
   logic [18:0]            in_imm_hi;
   logic                   uses_hi;

   logic                   sys_plain;
   logic                   csr_op;
   logic                   csr_valid;
   logic                   writes_rd;

   assign in_opcode = rv_serial_pkg::opcode_e'(i_instr[6:2]);

   // Control fields, reset to addi x0,x0,0
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         opcode     <= rv_serial_pkg::OP_IMM;
         funct3     <= 3'b000;
         bit30      <= 1'b0;
         o_rd_addr  <= 5'd0;
         o_rs1_addr <= 5'd0;
         o_rs2_addr <= 5'd0;
         op20       <= 1'b0;
         op21       <= 1'b0;
         op22       <= 1'b0;
         op26       <= 1'b0;
      end else if (i_load && !i_bit_en) begin
         opcode     <= in_opcode;
         funct3     <= i_instr[14:12];
         bit30      <= i_instr[30];
         o_rd_addr  <= i_instr[11:7];
         o_rs1_addr <= i_instr[19:15];
         o_rs2_addr <= i_instr[24:20];
         op20       <= i_instr[20];
         op21       <= i_instr[21];
         op22       <= i_instr[22];
         op26       <= i_instr[26];
      end
   end

   // Immediate pieces per format, lsb of B and J is always zero
   always_comb begin
      in_imm_hi = i_instr[30:12];
      case (in_opcode)
         rv_serial_pkg::STORE:  in_imm_lo = {i_instr[31:25], i_instr[11:7]};
         rv_serial_pkg::BRANCH: in_imm_lo = {i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
         rv_serial_pkg::JAL: begin
            in_imm_lo = {i_instr[20], i_instr[30:21], 1'b0};
            in_imm_hi = {{11{i_instr[31]}}, i_instr[19:12]};
         end
         rv_serial_pkg::LUI,
         rv_serial_pkg::AUIPC:  in_imm_lo = 12'd0;
         default:               in_imm_lo = i_instr[31:20];
      endcase
   end

   // Only J and U formats carry bits above 11 that differ from the sign
   assign uses_hi = (opcode == rv_serial_pkg::JAL) || (opcode == rv_serial_pkg::LUI) ||
                    (opcode == rv_serial_pkg::AUIPC);

   always_ff @(posedge clk) begin
      if (i_bit_en) begin
         imm_lo <= {uses_hi ? imm_hi[0] : signbit, imm_lo[11:1]};
         imm_hi <= {signbit, imm_hi[18:1]};
      end else if (i_load) begin
         signbit <= i_instr[31];
         imm_lo  <= in_imm_lo;
         imm_hi  <= in_imm_hi;
      end
   end

   // After 31 shifts the sign has reached bit 0
   assign ctrl.imm_bit = imm_lo[0];

   always_comb begin
      ctrl.alu_op = rv_serial_pkg::ADD;
      if (opcode == rv_serial_pkg::BRANCH) begin
         ctrl.alu_op = rv_serial_pkg::CMP;
      end else if ((opcode == rv_serial_pkg::OP) || (opcode == rv_serial_pkg::OP_IMM)) begin
         case (funct3)
            3'b000: begin
               if ((opcode == rv_serial_pkg::OP) && bit30) begin
                  ctrl.alu_op = rv_serial_pkg::SUB;
               end
            end
            3'b100:  ctrl.alu_op = rv_serial_pkg::XOR;
            3'b110:  ctrl.alu_op = rv_serial_pkg::OR;
            3'b111:  ctrl.alu_op = rv_serial_pkg::AND;
            default: ctrl.alu_op = rv_serial_pkg::ADD;
         endcase
      end
   end

   // beq/bne, blt/bge, bltu/bgeu
   always_comb begin
      case (funct3[2:1])
         2'b10:   ctrl.cmp_sel = rv_serial_pkg::LT;
         2'b11:   ctrl.cmp_sel = rv_serial_pkg::LTU;
         default: ctrl.cmp_sel = rv_serial_pkg::EQ;
      endcase
   end

   assign ctrl.cmp_neg   = funct3[0];
   assign ctrl.is_branch = (opcode == rv_serial_pkg::BRANCH);
   assign ctrl.op_b_imm  = !((opcode == rv_serial_pkg::OP) || (opcode == rv_serial_pkg::BRANCH));
   assign ctrl.zero_a    = (opcode == rv_serial_pkg::LUI);
   assign ctrl.rd_alu_en = !((opcode == rv_serial_pkg::BRANCH) ||
                             (opcode == rv_serial_pkg::SYSTEM));

   // System decode
   assign sys_plain = (opcode == rv_serial_pkg::SYSTEM) && (funct3 == 3'b000);
   assign csr_op    = (opcode == rv_serial_pkg::SYSTEM) && (funct3 != 3'b000);
   assign o_ecall   = sys_plain && !op20 && !op21;
   assign o_ebreak  = sys_plain && op20;
   assign o_mret    = sys_plain && op21;

   // mtvec, mscratch, mepc and mtval are the only CSRs held
   assign csr_valid = op20 || (op26 && !op22 && !op21);
   assign o_csr_en  = csr_op && csr_valid;
   assign o_csr_src = rv_csr_pkg::csr_src_e'(funct3[1:0]);

   always_comb begin
      if (op26 && !op20) begin
         o_csr_addr = rv_csr_pkg::MSCRATCH;
      end else if (op26 && !op21) begin
         o_csr_addr = rv_csr_pkg::MEPC;
      end else if (op26) begin
         o_csr_addr = rv_csr_pkg::MTVAL;
      end else begin
         o_csr_addr = rv_csr_pkg::MTVEC;
      end
   end

   // x0 is never written
   assign writes_rd = !((opcode == rv_serial_pkg::STORE) || (opcode == rv_serial_pkg::BRANCH) ||
                        sys_plain);
   assign o_rd_en   = writes_rd && (o_rd_addr != 5'd0);

endmodule

/* hdl/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu (
   input  logic    clk,
   input  logic    i_rst_n,
   input  logic    i_load,
   input  logic    i_bit_en,
   input  logic    i_last,
   input  logic    i_rs1_bit,
   input  logic    i_rs2_bit,
   alu_ctrl_if.alu ctrl,
   output logic    o_rd_bit,
   output logic    o_take_branch
);

   logic op_a;
   logic op_b_raw;
   logic b_inv;
   logic op_b;
   logic carry_st;
   logic carry_in;
   logic sum;
   logic cout;
   logic eq_acc;
   logic eq_bit;
   logic eq_now;
   logic lt_s;
   logic lt_u;
   logic cmp_res;
   logic res_bit;

   assign op_a     = ctrl.zero_a ? 1'b0 : i_rs1_bit;
   assign op_b_raw = ctrl.op_b_imm ? ctrl.imm_bit : i_rs2_bit;
   assign b_inv    = (ctrl.alu_op == rv_serial_pkg::SUB) || (ctrl.alu_op == rv_serial_pkg::CMP);
   assign op_b     = op_b_raw ^ b_inv;

   // Stored carry is relative to b_inv, so clearing it presets a one for sub
   assign carry_in = carry_st ^ b_inv;
   assign sum      = op_a ^ op_b ^ carry_in;
   assign cout     = (op_a & op_b) | (carry_in & (op_a ^ op_b));

   assign eq_bit = (op_a == op_b_raw);
   assign eq_now = eq_acc && eq_bit;

   // Valid in the last bit, op_a and op_b_raw are the sign bits there
   assign lt_u = !cout;
   assign lt_s = (op_a != op_b_raw) ? op_a : !cout;

   always_comb begin
      case (ctrl.cmp_sel)
         rv_serial_pkg::LT:  cmp_res = lt_s;
         rv_serial_pkg::LTU: cmp_res = lt_u;
         default:            cmp_res = eq_now;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         carry_st      <= 1'b0;
         eq_acc        <= 1'b1;
         o_take_branch <= 1'b0;
      end else if (i_bit_en) begin
         carry_st <= cout ^ b_inv;
         eq_acc   <= eq_now;
         if (i_last) begin
            o_take_branch <= ctrl.is_branch && (cmp_res ^ ctrl.cmp_neg);
         end
      end else if (i_load) begin
         carry_st      <= 1'b0;
         eq_acc        <= 1'b1;
         o_take_branch <= 1'b0;
      end
   end

   always_comb begin
      case (ctrl.alu_op)
         rv_serial_pkg::ADD,
         rv_serial_pkg::SUB: res_bit = sum;
         rv_serial_pkg::AND: res_bit = op_a & op_b_raw;
         rv_serial_pkg::OR:  res_bit = op_a | op_b_raw;
         rv_serial_pkg::XOR: res_bit = op_a ^ op_b_raw;
         default:            res_bit = 1'b0;
      endcase
   end

   assign o_rd_bit = ctrl.rd_alu_en && res_bit;

endmodule

/* hdl/exec_slice_top.sv */
`timescale 1ns/1ps

module exec_slice_top (
   input  logic        clk,
   input  logic        i_rst_n,
   input  logic        i_instr_load,
   input  logic [31:0] i_instr,
   input  logic        i_rs1_bit,
   input  logic        i_rs2_bit,
   output logic        o_bit_en,
   output logic        o_rd_bit,
   output logic        o_done,
   output logic        o_take_branch,
   output logic        o_rd_en,
   output logic [4:0]  o_rd_addr,
   output logic [4:0]  o_rs1_addr,
   output logic [4:0]  o_rs2_addr,
   output logic        o_csr_en,
   output logic [1:0]  o_csr_addr,
   output logic [1:0]  o_csr_src,
   output logic        o_ecall,
   output logic        o_ebreak,
   output logic        o_mret
);

   logic                  last;
   rv_csr_pkg::csr_addr_e csr_addr;
   rv_csr_pkg::csr_src_e  csr_src;

   alu_ctrl_if i_alu_ctrl ();

   bit_counter i_bit_counter (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_start  (i_instr_load),
      .o_bit_en (o_bit_en),
      .o_last   (last),
      .o_done   (o_done)
   );

   inst_decode i_inst_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_load     (i_instr_load),
      .i_instr    (i_instr),
      .i_bit_en   (o_bit_en),
      .o_rd_addr  (o_rd_addr),
      .o_rs1_addr (o_rs1_addr),
      .o_rs2_addr (o_rs2_addr),
      .o_rd_en    (o_rd_en),
      .o_ecall    (o_ecall),
      .o_ebreak   (o_ebreak),
      .o_mret     (o_mret),
      .o_csr_en   (o_csr_en),
      .o_csr_addr (csr_addr),
      .o_csr_src  (csr_src),
      .ctrl       (i_alu_ctrl.ctrl)
   );

   serial_alu i_serial_alu (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_load        (i_instr_load),
      .i_bit_en      (o_bit_en),
      .i_last        (last),
      .i_rs1_bit     (i_rs1_bit),
      .i_rs2_bit     (i_rs2_bit),
      .ctrl          (i_alu_ctrl.alu),
      .o_rd_bit      (o_rd_bit),
      .o_take_branch (o_take_branch)
   );

   // Plain vectors at the top ports
   assign o_csr_addr = 2'(csr_addr);
   assign o_csr_src  = 2'(csr_src);

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen (
   output logic clk,
   output logic o_rst_n
);

   // 10 ns period
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held for 10 cycles, released away from the rising edge
   initial begin
      o_rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      o_rst_n = 1'b1;
   end

endmodule

/* tb/exec_slice_assert.sv */
`timescale 1ns/1ps

module exec_slice_assert (
   input logic clk,
   input logic i_rst_n,
   input logic i_load,
   input logic i_bit_en,
   input logic i_done
);

   // Number of assertion failures seen so far
   int fail_cnt = 0;

   // Done pulses exactly one cycle after the bit window closes
   property done_after_window;
      @(posedge clk) disable iff (!i_rst_n)
         $fell(i_bit_en) |-> i_done;
   endproperty

   property done_only_after_window;
      @(posedge clk) disable iff (!i_rst_n)
         i_done |-> $fell(i_bit_en);
   endproperty

   // One bit per cycle over the whole word
   property window_is_32;
      @(posedge clk) disable iff (!i_rst_n)
         $rose(i_bit_en) |-> i_bit_en [*32] ##1 !i_bit_en;
   endproperty

   property no_load_when_busy;
      @(posedge clk) disable iff (!i_rst_n)
         i_bit_en |-> !i_load;
   endproperty

   done_after_window_a: assert property (done_after_window)
      else begin
         $error("o_done did not follow the end of the bit window");
         fail_cnt++;
      end
   done_only_after_window_a: assert property (done_only_after_window)
      else begin
         $error("o_done pulsed outside the cycle after the bit window");
         fail_cnt++;
      end
   window_is_32_a: assert property (window_is_32)
      else begin
         $error("o_bit_en was not high for exactly 32 cycles");
         fail_cnt++;
      end
   no_load_when_busy_a: assert property (no_load_when_busy)
      else begin
         $error("instruction load arrived while the slice was busy");
         fail_cnt++;
      end

endmodule

/* tb/exec_slice_tb.sv */
`timescale 1ns/1ps

module exec_slice_tb;

   typedef struct packed {
      logic [31:0] instr;
      logic [31:0] rs1;
      logic [31:0] rs2;
      logic [31:0] res;
      logic        take;
      logic        rd_en;
      // ecall, ebreak, mret, csr_en, csr_addr[1:0]
      logic [5:0]  sys;
   } entry_t;

   logic        clk;
   logic        i_rst_n;
   logic        i_instr_load;
   logic [31:0] i_instr;
   logic        i_rs1_bit;
   logic        i_rs2_bit;
   logic        o_bit_en;
   logic        o_rd_bit;
   logic        o_done;
   logic        o_take_branch;
   logic        o_rd_en;
   logic [4:0]  o_rd_addr;
   logic [4:0]  o_rs1_addr;
   logic [4:0]  o_rs2_addr;
   logic        o_csr_en;
   logic [1:0]  o_csr_addr;
   logic [1:0]  o_csr_src;
   logic        o_ecall;
   logic        o_ebreak;
   logic        o_mret;

   entry_t      table_q[$];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          timeout_lim;
   integer      seed = 23;

   clk_gen i_clk_gen (
      .clk     (clk),
      .o_rst_n (i_rst_n)
   );

   exec_slice_top i_exec_slice_top (.*);

   bind exec_slice_top exec_slice_assert i_exec_slice_assert (
      .clk      (clk),
      .i_rst_n  (i_rst_n),
      .i_load   (i_instr_load),
      .i_bit_en (o_bit_en),
      .i_done   (o_done)
   );

   function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] opc);
      return {f7, rs2, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [4:0] opc);
      return rtype_word(imm[11:5], imm[4:0], rs1, f3, rd, opc);
   endfunction

   function automatic logic [31:0] utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                              input logic [4:0] opc);
      return {imm, rd, opc, 2'b11};
   endfunction

   // Sign-extended immediate of the I, S and U formats
   function automatic logic [31:0] sext_imm(input logic [31:0] w);
      case (w[6:2])
         rv_serial_pkg::STORE: return {{20{w[31]}}, w[31:25], w[11:7]};
         rv_serial_pkg::LUI,
         rv_serial_pkg::AUIPC: return {w[31:12], 12'd0};
         default:              return {{20{w[31]}}, w[31:20]};
      endcase
   endfunction

   function automatic logic [31:0] exec_result(input logic [31:0] w, input logic [31:0] rs1,
                                               input logic [31:0] rs2);
      logic [4:0]  opc;
      logic [31:0] b;
      opc = w[6:2];
      b   = (opc == rv_serial_pkg::OP) ? rs2 : sext_imm(w);
      if ((opc == rv_serial_pkg::BRANCH) || (opc == rv_serial_pkg::SYSTEM)) begin
         return 32'd0;
      end else if (opc == rv_serial_pkg::LUI) begin
         return b;
      end else if ((opc == rv_serial_pkg::OP) || (opc == rv_serial_pkg::OP_IMM)) begin
         case (w[14:12])
            3'b100:  return rs1 ^ b;
            3'b110:  return rs1 | b;
            3'b111:  return rs1 & b;
            3'b000:  return ((opc == rv_serial_pkg::OP) && w[30]) ? rs1 - b : rs1 + b;
            default: return rs1 + b;
         endcase
      end
      return rs1 + b;
   endfunction

   function automatic logic branch_taken(input logic [31:0] w, input logic [31:0] rs1,
                                         input logic [31:0] rs2);
      logic hit;
      case (w[14:13])
         2'b10:   hit = ($signed(rs1) < $signed(rs2));
         2'b11:   hit = (rs1 < rs2);
         default: hit = (rs1 == rs2);
      endcase
      return (w[6:2] == rv_serial_pkg::BRANCH) && (hit ^ w[12]);
   endfunction

   function automatic logic rd_written(input logic [31:0] w);
      logic [4:0] opc;
      opc = w[6:2];
      if ((opc == rv_serial_pkg::STORE) || (opc == rv_serial_pkg::BRANCH) ||
          ((opc == rv_serial_pkg::SYSTEM) && (w[14:12] == 3'b000))) begin
         return 1'b0;
      end
      return (w[11:7] != 5'd0);
   endfunction

   function automatic logic [5:0] sys_flags(input logic [31:0] w);
      logic       sys;
      logic       plain;
      logic       hit;
      logic [1:0] addr;
      sys   = (w[6:2] == rv_serial_pkg::SYSTEM);
      plain = sys && (w[14:12] == 3'b000);
      hit   = 1'b1;
      case (w[31:20])
         12'h340: addr = rv_csr_pkg::MSCRATCH;
         12'h305: addr = rv_csr_pkg::MTVEC;
         12'h341: addr = rv_csr_pkg::MEPC;
         12'h343: addr = rv_csr_pkg::MTVAL;
         default: begin
            addr = 2'b00;
            hit  = 1'b0;
         end
      endcase
      return {plain && (w[31:20] == 12'h000), plain && (w[31:20] == 12'h001),
              plain && (w[31:20] == 12'h302), sys && !plain && hit, addr};
   endfunction

   task automatic add_entry(input logic [31:0] w, input logic [31:0] rs1,
                            input logic [31:0] rs2);
      entry_t e;
      e.instr = w;
      e.rs1   = rs1;
      e.rs2   = rs2;
      e.res   = exec_result(w, rs1, rs2);
      e.take  = branch_taken(w, rs1, rs2);
      e.rd_en = rd_written(w);
      e.sys   = sys_flags(w);
      table_q.push_back(e);
   endtask

   task automatic build_table();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] w;
      // add and sub
      for (int n = 0; n < 4; n++) begin
         a = $random(seed);
         b = $random(seed);
         add_entry(rtype_word(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv_serial_pkg::OP), a, b);
         add_entry(rtype_word(7'h20, 5'd12, 5'd11, 3'b000, 5'd13, rv_serial_pkg::OP), a, b);
      end
      // xor, or and and, register and immediate forms
      for (int f = 4; f < 8; f++) begin
         if (f != 5) begin
            a = $random(seed);
            b = $random(seed);
            add_entry(rtype_word(7'h00, 5'd5, 5'd4, 3'(f), 5'd6, rv_serial_pkg::OP), a, b);
            add_entry(itype_word(12'h8A5, 5'd4, 3'(f), 5'd7, rv_serial_pkg::OP_IMM), a, b);
            add_entry(itype_word(12'h35C, 5'd4, 3'(f), 5'd8, rv_serial_pkg::OP_IMM), a, b);
         end
      end
      add_entry(itype_word(12'hFFF, 5'd1, 3'b000, 5'd9, rv_serial_pkg::OP_IMM), a, b);
      // Six branch types over equal, signed and unsigned pairs
      for (int f = 0; f < 8; f++) begin
         if ((f != 2) && (f != 3)) begin
            w = rtype_word(7'h00, 5'd2, 5'd1, 3'(f), 5'd8, rv_serial_pkg::BRANCH);
            add_entry(w, 32'h0000_1234, 32'h0000_1234);
            add_entry(w, 32'hFFFF_FFF0, 32'h0000_0003);
            add_entry(w, 32'h0000_0003, 32'h8000_0000);
         end
      end
      // U immediates and a store address with offset -4
      add_entry(utype_word(20'hABCDE, 5'd10, rv_serial_pkg::LUI), a, b);
      add_entry(utype_word(20'h80001, 5'd11, rv_serial_pkg::AUIPC), a, b);
      add_entry(rtype_word(7'h7F, 5'd9, 5'd3, 3'b010, 5'h1C, rv_serial_pkg::STORE), a, b);
      // ecall, ebreak, mret, then one access per short CSR address
      add_entry(32'h0000_0073, a, b);
      add_entry(32'h0010_0073, a, b);
      add_entry(32'h3020_0073, a, b);
      add_entry(itype_word(12'h340, 5'd1, 3'b001, 5'd5, rv_serial_pkg::SYSTEM), a, b);
      add_entry(itype_word(12'h305, 5'd1, 3'b010, 5'd5, rv_serial_pkg::SYSTEM), a, b);
      add_entry(itype_word(12'h341, 5'd1, 3'b011, 5'd0, rv_serial_pkg::SYSTEM), a, b);
      add_entry(itype_word(12'h343, 5'd7, 3'b101, 5'd6, rv_serial_pkg::SYSTEM), a, b);
   endtask

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > timeout_lim) begin
         $display("Run stopped after %0d cycles, the table did not finish", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial begin
      entry_t      e;
      logic [31:0] got;
      int          k;
      int          cyc;
      i_instr_load = 1'b0;
      i_instr      = 32'd0;
      i_rs1_bit    = 1'b0;
      i_rs2_bit    = 1'b0;
      build_table();
      timeout_lim = table_q.size() * 40 + 50;
      @(posedge i_rst_n);
      @(negedge clk);
      // Idle state after reset
      check_value("o_bit_en", 0, o_bit_en);
      check_value("o_done", 0, o_done);
      check_value("o_take_branch", 0, o_take_branch);
      check_value("o_rd_en", 0, o_rd_en);
      check_value("{o_ecall,o_ebreak,o_mret,o_csr_en}", 0, {o_ecall, o_ebreak, o_mret, o_csr_en});
      foreach (table_q[i]) begin
         e            = table_q[i];
         i_instr      = e.instr;
         i_instr_load = 1'b1;
         @(negedge clk);
         i_instr_load = 1'b0;
         cyc = 1;
         k   = 0;
         got = 32'd0;
         // Bit k goes in and comes out in the same cycle
         while (o_bit_en && (k < 32)) begin
            i_rs1_bit = e.rs1[k];
            i_rs2_bit = e.rs2[k];
            #2;
            got[k] = o_rd_bit;
            k++;
            @(negedge clk);
            cyc++;
         end
         while (!o_done) begin
            @(negedge clk);
            cyc++;
         end
         check_value("cycles load to o_done", 33, cyc);
         check_value("o_bit_en cycles", 32, k);
         check_value("o_rd_bit word", e.res, got);
         check_value("o_take_branch", e.take, o_take_branch);
         check_value("o_rd_en", e.rd_en, o_rd_en);
         check_value("o_rd_addr", e.instr[11:7], o_rd_addr);
         check_value("o_rs1_addr", e.instr[19:15], o_rs1_addr);
         check_value("o_rs2_addr", e.instr[24:20], o_rs2_addr);
         check_value("{o_ecall,o_ebreak,o_mret,o_csr_en}", e.sys[5:2],
                     {o_ecall, o_ebreak, o_mret, o_csr_en});
         if (e.sys[2]) begin
            check_value("o_csr_addr", e.sys[1:0], o_csr_addr);
            check_value("o_csr_src", e.instr[13:12], o_csr_src);
         end
         @(negedge clk);
      end
      // Failures of the bound strobe checker count as errors too
      errors += i_exec_slice_top.i_exec_slice_assert.fail_cnt;
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

/* all.f */
hdl/rv_serial_pkg.sv
hdl/rv_csr_pkg.sv
hdl/alu_ctrl_if.sv
hdl/bit_counter.sv
hdl/inst_decode.sv
hdl/serial_alu.sv
hdl/exec_slice_top.sv
tb/clk_gen.sv
tb/exec_slice_assert.sv
tb/exec_slice_tb.sv

/* Bender.yml */
package:
  name: exec_slice

sources:
  - files:
      - hdl/rv_serial_pkg.sv
      - hdl/rv_csr_pkg.sv
      - hdl/alu_ctrl_if.sv
      - hdl/bit_counter.sv
      - hdl/inst_decode.sv
      - hdl/serial_alu.sv
      - hdl/exec_slice_top.sv
  - target: simulation
    files:
      - tb/clk_gen.sv
      - tb/exec_slice_assert.sv
      - tb/exec_slice_tb.sv
